// ==== tests/frame_buf_input.txt ====
# code wr_begin wr_end rd_begin rd_end words_in words_out stall_pct (addresses in hex)
# code 1 idle, 2 round trip, 3 write wrap, 4 read wrap, 5 concurrent, 6 partial burst
1 00 00 00 00 0 0 0
2 00 1f 00 1f 32 32 0
3 20 3f 20 3f 64 32 0
4 00 00 20 3f 0 80 40
5 40 7f 00 1f 64 48 25
5 80 bf 40 7f 40 64 50
4 00 00 80 bf 0 72 70
2 c0 df c0 df 32 32 20
6 00 1f 00 1f 29 40 10

// ==== all.f ====
+incdir+logic
logic/frame_buf_pkg.sv
logic/wr_burst_ctrl.sv
logic/burst_arbiter.sv
logic/mem_burst_engine.sv
logic/rd_burst_ctrl.sv
logic/frame_buf_top.sv
tests/frame_buf_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = frame_buf_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/frame_buf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buf_tb;

  localparam int BURST_LEN = 8;
  localparam int MEM_WORDS = 256;
  localparam int MAX_CASES = 32;
  localparam int WR_SETTLE = 80;   // staged bursts still landing
  localparam int RD_QUIET  = 40;

  logic                 ref_clk_bypass;
  logic                 rst_n;
  logic                 wr_enable;
  logic                 rd_enable;
  frame_buf_pkg::addr_t wr_b_addr;
  frame_buf_pkg::addr_t wr_e_addr;
  frame_buf_pkg::addr_t rd_b_addr;
  frame_buf_pkg::addr_t rd_e_addr;
  logic                 in_valid;
  frame_buf_pkg::word_t in_data;
  logic                 in_ready;
  logic                 out_valid;
  frame_buf_pkg::word_t out_data;
  logic                 out_ready;

  frame_buf_pkg::word_t ref_mem [0:MEM_WORDS-1];
  frame_buf_pkg::word_t stage_q [$];   // words not yet forming a burst
  frame_buf_pkg::addr_t model_wr_ptr;
  frame_buf_pkg::addr_t model_rd_base;
  int                   model_rd_off;
  logic [31:0]          lcg_state;

  int code [MAX_CASES];
  int wb [MAX_CASES];
  int we [MAX_CASES];
  int rb [MAX_CASES];
  int re [MAX_CASES];
  int nwr [MAX_CASES];
  int nrd [MAX_CASES];
  int stall [MAX_CASES];
  int num_cases;
  int total_words;

  frame_buf_top frame_buf_top_i (
    .ref_clk_bypass (ref_clk_bypass),
    .rst_n          (rst_n),
    .wr_enable      (wr_enable),
    .rd_enable      (rd_enable),
    .wr_b_addr      (wr_b_addr),
    .wr_e_addr      (wr_e_addr),
    .rd_b_addr      (rd_b_addr),
    .rd_e_addr      (rd_e_addr),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_ready      (out_ready)
  );

  initial begin
    ref_clk_bypass = 1'b0;
    forever #4 ref_clk_bypass = ~ref_clk_bypass;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // next burst start with wrap back to begin
  function automatic frame_buf_pkg::addr_t step_region(input frame_buf_pkg::addr_t ptr,
                                                       input frame_buf_pkg::addr_t b,
                                                       input frame_buf_pkg::addr_t e);
    int nxt;
    nxt = int'(ptr) + BURST_LEN;
    if (nxt > int'(e)) begin
      return b;
    end
    return frame_buf_pkg::addr_t'(nxt);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic stage_word(input frame_buf_pkg::word_t w);
    int k;
    stage_q.push_back(w);
    if (stage_q.size() == BURST_LEN) begin   // full burst goes to memory
      for (k = 0; k < BURST_LEN; k++) begin
        ref_mem[int'(model_wr_ptr) + k] = stage_q.pop_front();
      end
      model_wr_ptr = step_region(model_wr_ptr, wr_b_addr, wr_e_addr);
    end
  endtask

  task automatic next_expected(output frame_buf_pkg::word_t w);
    w = ref_mem[int'(model_rd_base) + model_rd_off];
    model_rd_off++;
    if (model_rd_off == BURST_LEN) begin
      model_rd_off  = 0;
      model_rd_base = step_region(model_rd_base, rd_b_addr, rd_e_addr);
    end
  endtask

  task automatic write_words(input int n);
    int sent;
    bit took;
    sent      = 0;
    wr_enable = 1'b1;
    if (n > 0) begin
      in_data  = lcg_next();
      in_valid = 1'b1;
    end
    while (sent < n) begin
      @(negedge ref_clk_bypass);
      took = in_ready;
      @(posedge ref_clk_bypass);
      #1;
      if (took) begin
        stage_word(in_data);
        sent++;
        if (sent < n) begin
          in_data = lcg_next();
        end else begin
          in_valid = 1'b0;
        end
      end
    end
    repeat (WR_SETTLE) @(posedge ref_clk_bypass);
    #1;
    wr_enable = 1'b0;
  endtask

  // every address gets a known word before the first read
  task automatic fill_memory();
    wr_b_addr    = '0;
    wr_e_addr    = frame_buf_pkg::addr_t'(MEM_WORDS - 1);
    model_wr_ptr = '0;
    @(posedge ref_clk_bypass);
    #1;
    write_words(MEM_WORDS);
  endtask

  task automatic read_words(input int n, input int stall_pct);
    int                   got_cnt;
    int                   quiet;
    bit                   took;
    frame_buf_pkg::word_t data;
    frame_buf_pkg::word_t exp_word;
    got_cnt       = 0;
    model_rd_base = rd_b_addr;
    model_rd_off  = 0;
    rd_enable     = 1'b1;
    while (got_cnt < n) begin
      out_ready = ((lcg_next() >> 16) % 100) >= 32'(stall_pct);
      @(negedge ref_clk_bypass);
      took = out_valid && out_ready;
      data = out_data;
      @(posedge ref_clk_bypass);
      #1;
      if (took) begin
        next_expected(exp_word);
        check_eq(data, exp_word, $sformatf("read word %0d", got_cnt));
        got_cnt++;
      end
    end
    rd_enable = 1'b0;   // stop new requests and drain prefetched words
    out_ready = 1'b1;
    quiet     = 0;
    while (quiet < RD_QUIET) begin
      @(negedge ref_clk_bypass);
      took = out_valid;
      data = out_data;
      @(posedge ref_clk_bypass);
      #1;
      if (took) begin
        next_expected(exp_word);
        check_eq(data, exp_word, "drained read word");
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    out_ready = 1'b0;
  endtask

  task automatic idle_check();
    repeat (20) begin
      @(negedge ref_clk_bypass);
      check_eq(32'(in_ready), 32'd0, "in_ready while idle");
      check_eq(32'(out_valid), 32'd0, "out_valid while idle");
    end
    @(posedge ref_clk_bypass);
    #1;
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge ref_clk_bypass);
    abort_run($sformatf("timeout, the run did not finish within %0d cycles", cycles));
  endtask

  task automatic load_cases();
    int    fd;
    int    r;
    string line;
    num_cases   = 0;
    total_words = 0;
    fd = $fopen("tests/frame_buf_input.txt", "r");
    if (fd == 0) begin
      abort_run("could not open tests/frame_buf_input.txt");
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 1 && line.getc(0) != 8'h23) begin
          r = $sscanf(line, "%d %h %h %h %h %d %d %d", code[num_cases], wb[num_cases],
                      we[num_cases], rb[num_cases], re[num_cases], nwr[num_cases],
                      nrd[num_cases], stall[num_cases]);
          if (r != 8) begin
            abort_run({"badly formed test case line: ", line});
          end else begin
            total_words += nwr[num_cases] + nrd[num_cases];
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(input int i);
    wr_b_addr    = frame_buf_pkg::addr_t'(wb[i]);
    wr_e_addr    = frame_buf_pkg::addr_t'(we[i]);
    rd_b_addr    = frame_buf_pkg::addr_t'(rb[i]);
    rd_e_addr    = frame_buf_pkg::addr_t'(re[i]);
    model_wr_ptr = wr_b_addr;
    @(posedge ref_clk_bypass);   // pointers pick up the new begin addresses
    #1;
    $display("case %0d: code %0d, %0d words in, %0d words out", i, code[i], nwr[i], nrd[i]);
    if (code[i] == 1) begin
      idle_check();
    end else if (code[i] == 5) begin
      fork
        write_words(nwr[i]);
        if (nrd[i] > 0) read_words(nrd[i], stall[i]);
      join
    end else begin
      if (nwr[i] > 0) write_words(nwr[i]);
      if (nrd[i] > 0) read_words(nrd[i], stall[i]);
    end
  endtask

  initial begin
    int limit;
    int i;
    bit mem_filled;
    lcg_state  = 32'hd32c_1d49;
    rst_n      = 1'b0;
    wr_enable  = 1'b0;
    rd_enable  = 1'b0;
    wr_b_addr  = '0;
    wr_e_addr  = '0;
    rd_b_addr  = '0;
    rd_e_addr  = '0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b0;
    mem_filled = 1'b0;
    load_cases();
    limit = (total_words + MEM_WORDS) * 200 + num_cases * 400;
    fork
      watchdog(limit);
    join_none
    repeat (10) @(posedge ref_clk_bypass);
    #1;
    rst_n = 1'b1;
    for (i = 0; i < num_cases; i++) begin
      if (code[i] != 1 && !mem_filled) begin
        fill_memory();
        mem_filled = 1'b1;
      end
      run_case(i);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/frame_buf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buf_top (
  input  wire                        ref_clk_bypass,
  input  wire                        rst_n,
  input  wire                        wr_enable,
  input  wire                        rd_enable,
  input  wire  frame_buf_pkg::addr_t wr_b_addr,
  input  wire  frame_buf_pkg::addr_t wr_e_addr,
  input  wire  frame_buf_pkg::addr_t rd_b_addr,
  input  wire  frame_buf_pkg::addr_t rd_e_addr,
  input  wire                        in_valid,
  input  wire  frame_buf_pkg::word_t in_data,
  output logic                       in_ready,
  output logic                       out_valid,
  output frame_buf_pkg::word_t       out_data,
  input  wire                        out_ready
);

  logic                     wr_req_valid;
  logic                     wr_req_ready;
  frame_buf_pkg::addr_t     wr_req_addr;
  logic                     rd_req_valid;
  logic                     rd_req_ready;
  frame_buf_pkg::addr_t     rd_req_addr;
  logic                     cmd_valid;
  logic                     cmd_ready;
  frame_buf_pkg::burst_op_e cmd_op;
  frame_buf_pkg::addr_t     cmd_addr;
  logic                     wr_pop;
  frame_buf_pkg::word_t     wr_word;
  logic                     rd_push;
  frame_buf_pkg::word_t     rd_word;

  wr_burst_ctrl wr_burst_ctrl_i (
    .ref_clk_bypass (ref_clk_bypass),
    .rst_n          (rst_n),
    .wr_enable      (wr_enable),
    .wr_b_addr      (wr_b_addr),
    .wr_e_addr      (wr_e_addr),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .wr_req_ready   (wr_req_ready),
    .wr_pop         (wr_pop),
    .in_ready       (in_ready),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .wr_word        (wr_word)
  );

  burst_arbiter burst_arbiter_i (
    .ref_clk_bypass (ref_clk_bypass),
    .rst_n          (rst_n),
    .wr_req_valid   (wr_req_valid),
    .wr_req_addr    (wr_req_addr),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .cmd_ready      (cmd_ready),
    .wr_req_ready   (wr_req_ready),
    .rd_req_ready   (rd_req_ready),
    .cmd_valid      (cmd_valid),
    .cmd_op         (cmd_op),
    .cmd_addr       (cmd_addr)
  );

  mem_burst_engine mem_burst_engine_i (
    .ref_clk_bypass (ref_clk_bypass),
    .rst_n          (rst_n),
    .cmd_valid      (cmd_valid),
    .cmd_op         (cmd_op),
    .cmd_addr       (cmd_addr),
    .wr_word        (wr_word),
    .cmd_ready      (cmd_ready),
    .wr_pop         (wr_pop),
    .rd_push        (rd_push),
    .rd_word        (rd_word)
  );

  rd_burst_ctrl rd_burst_ctrl_i (
    .ref_clk_bypass (ref_clk_bypass),
    .rst_n          (rst_n),
    .rd_enable      (rd_enable),
    .rd_b_addr      (rd_b_addr),
    .rd_e_addr      (rd_e_addr),
    .rd_req_ready   (rd_req_ready),
    .rd_push        (rd_push),
    .rd_word        (rd_word),
    .out_ready      (out_ready),
    .rd_req_valid   (rd_req_valid),
    .rd_req_addr    (rd_req_addr),
    .out_valid      (out_valid),
    .out_data       (out_data)
  );

endmodule

`default_nettype wire

// ==== logic/rd_burst_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frame_buf_config.svh"

module rd_burst_ctrl (
  input  wire                        ref_clk_bypass,
  input  wire                        rst_n,
  input  wire                        rd_enable,
  input  wire  frame_buf_pkg::addr_t rd_b_addr,
  input  wire  frame_buf_pkg::addr_t rd_e_addr,   // last word of region
  input  wire                        rd_req_ready,
  input  wire                        rd_push,
  input  wire  frame_buf_pkg::word_t rd_word,
  input  wire                        out_ready,
  output logic                       rd_req_valid,
  output frame_buf_pkg::addr_t       rd_req_addr,
  output logic                       out_valid,
  output frame_buf_pkg::word_t       out_data
);

  localparam int PTR_W = $clog2(`FB_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  frame_buf_pkg::word_t fifo_mem [0:`FB_FIFO_DEPTH-1];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     fifo_cnt;
  logic [CNT_W-1:0]     in_flight;   // requested but not yet pushed
  logic [CNT_W:0]       committed;
  logic [`FB_ADDR_W:0]  next_addr;
  logic                 pop;
  logic                 req_take;

  assign out_valid    = (fifo_cnt != '0);
  assign out_data     = fifo_mem[rd_ptr];
  assign pop          = out_valid && out_ready;
  assign committed    = {1'b0, fifo_cnt} + {1'b0, in_flight};
  // credit check for room of a whole burst
  assign rd_req_valid = rd_enable &&
                        (committed <= (CNT_W+1)'(`FB_FIFO_DEPTH - `FB_BURST_LEN));
  assign req_take     = rd_req_valid && rd_req_ready;
  assign next_addr    = {1'b0, rd_req_addr} + (`FB_ADDR_W+1)'(`FB_BURST_LEN);

  always_ff @(posedge ref_clk_bypass) begin
    if (rd_push) begin
      fifo_mem[wr_ptr] <= rd_word;
    end
  end

  always_ff @(posedge ref_clk_bypass or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fifo_cnt    <= '0;
      in_flight   <= '0;
      rd_req_addr <= '0;
    end else begin
      if (rd_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rd_push, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      case ({req_take, rd_push})
        2'b10:   in_flight <= in_flight + CNT_W'(`FB_BURST_LEN);
        2'b01:   in_flight <= in_flight - 1'b1;
        2'b11:   in_flight <= in_flight + CNT_W'(`FB_BURST_LEN - 1);
        default: in_flight <= in_flight;
      endcase
      if (!rd_enable) begin
        rd_req_addr <= rd_b_addr;
      end else if (req_take) begin
        rd_req_addr <= (next_addr > {1'b0, rd_e_addr}) ? rd_b_addr
                                                        : next_addr[`FB_ADDR_W-1:0];
      end
    end
  end

  // the credit count must keep engine pushes from ever meeting a full FIFO
  a_rd_no_overflow: assert property (@(posedge ref_clk_bypass) disable iff (!rst_n)
    rd_push && !pop |-> fifo_cnt < CNT_W'(`FB_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== logic/mem_burst_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frame_buf_config.svh"

module mem_burst_engine (
  input  wire                            ref_clk_bypass,
  input  wire                            rst_n,
  input  wire                            cmd_valid,
  input  wire  frame_buf_pkg::burst_op_e cmd_op,
  input  wire  frame_buf_pkg::addr_t     cmd_addr,
  input  wire  frame_buf_pkg::word_t     wr_word,
  output logic                           cmd_ready,
  output logic                           wr_pop,
  output logic                           rd_push,
  output frame_buf_pkg::word_t           rd_word
);

  localparam int BEAT_W = $clog2(`FB_BURST_LEN);

  frame_buf_pkg::word_t     mem [0:`FB_MEM_DEPTH-1];
  frame_buf_pkg::burst_op_e cur_op;
  frame_buf_pkg::addr_t     cur_addr;
  frame_buf_pkg::addr_t     rd_addr;
  logic [BEAT_W-1:0]        beat;
  logic                     busy;
  logic                     last_beat;
  logic                     accept;
  logic                     rd_issue;

  assign cmd_ready = !busy;
  assign accept    = cmd_valid && cmd_ready;
  assign last_beat = (beat == BEAT_W'(`FB_BURST_LEN - 1));
  assign wr_pop    = busy && (cur_op == frame_buf_pkg::op_write);
  // reads run one word ahead so the registered data lines up with the busy beats
  assign rd_issue  = (accept && cmd_op == frame_buf_pkg::op_read) ||
                     (busy && cur_op == frame_buf_pkg::op_read && !last_beat);
  assign rd_addr   = accept ? cmd_addr : cur_addr + frame_buf_pkg::addr_t'(1);

  always_ff @(posedge ref_clk_bypass or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      beat     <= '0;
      cur_op   <= frame_buf_pkg::op_write;
      cur_addr <= '0;
      rd_push  <= 1'b0;
    end else begin
      rd_push <= rd_issue;
      if (accept) begin
        busy     <= 1'b1;
        cur_op   <= cmd_op;
        cur_addr <= cmd_addr;
        beat     <= '0;
      end else if (busy) begin
        cur_addr <= cur_addr + frame_buf_pkg::addr_t'(1);
        beat     <= beat + 1'b1;
        if (last_beat) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge ref_clk_bypass) begin
    if (wr_pop) begin
      mem[cur_addr] <= wr_word;
    end
    if (rd_issue) begin
      rd_word <= mem[rd_addr];   // registered read
    end
  end

  a_no_pop_push: assert property (@(posedge ref_clk_bypass) disable iff (!rst_n)
    !(wr_pop && rd_push));

endmodule

`default_nettype wire

// ==== logic/burst_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_arbiter (
  input  wire                        ref_clk_bypass,
  input  wire                        rst_n,
  input  wire                        wr_req_valid,
  input  wire  frame_buf_pkg::addr_t wr_req_addr,
  input  wire                        rd_req_valid,
  input  wire  frame_buf_pkg::addr_t rd_req_addr,
  input  wire                        cmd_ready,
  output logic                       wr_req_ready,
  output logic                       rd_req_ready,
  output logic                       cmd_valid,
  output frame_buf_pkg::burst_op_e   cmd_op,
  output frame_buf_pkg::addr_t       cmd_addr
);

  frame_buf_pkg::arb_state_e last_grant;
  logic                      slot_free;
  logic                      pick_rd;

  assign slot_free    = !cmd_valid || cmd_ready;   // refill as engine takes it
  assign pick_rd      = rd_req_valid &&
                        (!wr_req_valid || last_grant == frame_buf_pkg::last_wr);
  assign wr_req_ready = slot_free && wr_req_valid && !pick_rd;
  assign rd_req_ready = slot_free && pick_rd;

  always_ff @(posedge ref_clk_bypass or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid  <= 1'b0;
      last_grant <= frame_buf_pkg::last_rd;
    end else if (wr_req_ready) begin
      cmd_valid  <= 1'b1;
      last_grant <= frame_buf_pkg::last_wr;
    end else if (rd_req_ready) begin
      cmd_valid  <= 1'b1;
      last_grant <= frame_buf_pkg::last_rd;
    end else if (cmd_ready) begin
      cmd_valid  <= 1'b0;
    end
  end

  always_ff @(posedge ref_clk_bypass) begin
    if (wr_req_ready) begin
      cmd_op   <= frame_buf_pkg::op_write;
      cmd_addr <= wr_req_addr;
    end else if (rd_req_ready) begin
      cmd_op   <= frame_buf_pkg::op_read;
      cmd_addr <= rd_req_addr;
    end
  end

  a_cmd_hold: assert property (@(posedge ref_clk_bypass) disable iff (!rst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_op) && $stable(cmd_addr));

endmodule

`default_nettype wire

// ==== logic/wr_burst_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "frame_buf_config.svh"

module wr_burst_ctrl (
  input  wire                        ref_clk_bypass,
  input  wire                        rst_n,
  input  wire                        wr_enable,
  input  wire  frame_buf_pkg::addr_t wr_b_addr,
  input  wire  frame_buf_pkg::addr_t wr_e_addr,   // last word of region
  input  wire                        in_valid,
  input  wire  frame_buf_pkg::word_t in_data,
  input  wire                        wr_req_ready,
  input  wire                        wr_pop,
  output logic                       in_ready,
  output logic                       wr_req_valid,
  output frame_buf_pkg::addr_t       wr_req_addr,
  output frame_buf_pkg::word_t       wr_word
);

  localparam int PTR_W = $clog2(`FB_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  frame_buf_pkg::word_t fifo_mem [0:`FB_FIFO_DEPTH-1];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     fifo_cnt;
  logic [CNT_W-1:0]     unclaimed;   // staged but not yet requested
  logic [`FB_ADDR_W:0]  next_addr;
  logic                 push;
  logic                 req_take;

  assign in_ready     = wr_enable && (fifo_cnt != CNT_W'(`FB_FIFO_DEPTH));
  assign push         = in_valid && in_ready;
  assign wr_req_valid = wr_enable && (unclaimed >= CNT_W'(`FB_BURST_LEN));
  assign req_take     = wr_req_valid && wr_req_ready;
  assign wr_word      = fifo_mem[rd_ptr];   // head word taken on pop
  assign next_addr    = {1'b0, wr_req_addr} + (`FB_ADDR_W+1)'(`FB_BURST_LEN);

  always_ff @(posedge ref_clk_bypass) begin
    if (push) begin
      fifo_mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge ref_clk_bypass or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fifo_cnt    <= '0;
      unclaimed   <= '0;
      wr_req_addr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (wr_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, wr_pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      case ({push, req_take})
        2'b10:   unclaimed <= unclaimed + 1'b1;
        2'b01:   unclaimed <= unclaimed - CNT_W'(`FB_BURST_LEN);
        2'b11:   unclaimed <= unclaimed - CNT_W'(`FB_BURST_LEN - 1);
        default: unclaimed <= unclaimed;
      endcase
      if (!wr_enable) begin
        wr_req_addr <= wr_b_addr;
      end else if (req_take) begin
        wr_req_addr <= (next_addr > {1'b0, wr_e_addr}) ? wr_b_addr
                                                        : next_addr[`FB_ADDR_W-1:0];
      end
    end
  end

  a_wr_fifo_bound: assert property (@(posedge ref_clk_bypass) disable iff (!rst_n)
    fifo_cnt <= CNT_W'(`FB_FIFO_DEPTH));
  a_wr_pop_staged: assert property (@(posedge ref_clk_bypass) disable iff (!rst_n)
    wr_pop |-> fifo_cnt != '0);   // engine only pops claimed words

endmodule

`default_nettype wire

// ==== logic/frame_buf_pkg.sv ====
`default_nettype none
`include "frame_buf_config.svh"

package frame_buf_pkg;

  typedef logic [`FB_DATA_W-1:0] word_t;
  typedef logic [`FB_ADDR_W-1:0] addr_t;

  typedef enum logic {
    op_write = 1'b0,
    op_read  = 1'b1
  } burst_op_e;

  // side that won the last grant
  typedef enum logic {
    last_wr = 1'b0,
    last_rd = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

// ==== logic/frame_buf_config.svh ====
`ifndef FRAME_BUF_CONFIG_SVH
`define FRAME_BUF_CONFIG_SVH

// word and address widths
`define FB_DATA_W      32
`define FB_ADDR_W      8

`define FB_BURST_LEN   8    // words per burst as a power of two
`define FB_MEM_DEPTH   256
`define FB_FIFO_DEPTH  16   // two bursts

`endif
